//--- vga_macros.svh
`ifndef VGA_MACROS_SVH
`define VGA_MACROS_SVH

// --------------------
// raster timing
// --------------------

// dclk cycles per line
`define VGA_HPIXELS 800
// lines per frame
`define VGA_VLINES 521
// sync pulse lengths
`define VGA_HPULSE 96
`define VGA_VPULSE 2
// first active cycle, first cycle past the active area
`define VGA_HBP 144
`define VGA_HFP 784
// first active line, first line past the active area
`define VGA_VBP 31
`define VGA_VFP 511

// --------------------
// field geometry
// --------------------

// white bars at both sides
`define VGA_BAR_W 80
`define VGA_ACTIVE_W (`VGA_HFP - `VGA_HBP)

// enemy rows
`define ENEMY_SLOTS 5
`define ENEMY_PITCH 40

// half sizes of the boxes around a sprite centre
`define SPRITE_HALF 10
`define SHOT_HALF_W 5
`define SHOT_HALF_H 10

// --------------------
// title banner, active-area pixels
// --------------------

`define TITLE_X0 220
`define TITLE_Y0 200
`define TITLE_UL_X0 245
`define TITLE_UL_X1 360
`define TITLE_UL_Y0 230
`define TITLE_UL_Y1 235

`endif

//--- vga_pkg.sv
`include "vga_macros.svh"

package vga_pkg;

	// raster counter or active-area position
	typedef logic [9:0] coord_t;

	// 3-3-2 colour, red in the top bits as on the DAC pins
	typedef struct packed {
		logic [2:0] r;
		logic [2:0] g;
		logic [1:0] b;
	} rgb_t;

	// one bit per enemy slot, set once the enemy is hit
	typedef logic [`ENEMY_SLOTS-1:0] enemy_mask_t;

	// --------------------
	// palette
	// --------------------

	localparam rgb_t C_BLACK = '{r: 3'b000, g: 3'b000, b: 2'b00};
	localparam rgb_t C_WHITE = '{r: 3'b111, g: 3'b111, b: 2'b11};
	localparam rgb_t C_RED = '{r: 3'b111, g: 3'b000, b: 2'b00};
	localparam rgb_t C_GREEN = '{r: 3'b000, g: 3'b111, b: 2'b00};
	// boss colour
	localparam rgb_t C_MAGENTA = '{r: 3'b111, g: 3'b000, b: 2'b11};

endpackage

//--- raster_if.sv
interface raster_if;

	// raw counters
	vga_pkg::coord_t hc;
	vga_pkg::coord_t vc;

	// position inside the 640x480 area
	vga_pkg::coord_t ax;
	vga_pkg::coord_t ay;

	// active range flags
	logic active_v;
	logic active_h;

	// sync levels, low during the pulse
	logic hsync_n;
	logic vsync_n;

	// timing generator side
	modport source
	(
		output hc, vc, ax, ay, active_v, active_h, hsync_n, vsync_n
	);

	// layers and output stage
	modport sink
	(
		input hc, vc, ax, ay, active_v, active_h, hsync_n, vsync_n
	);

endinterface

//--- vga_timing.sv
`include "vga_macros.svh"

module vga_timing
(
	input logic dclk,
	input logic clr,
	raster_if.source rst
);

	localparam vga_pkg::coord_t H_LAST = vga_pkg::coord_t'(`VGA_HPIXELS - 1);
	localparam vga_pkg::coord_t V_LAST = vga_pkg::coord_t'(`VGA_VLINES - 1);

	vga_pkg::coord_t hc;
	vga_pkg::coord_t vc;
	logic line_end;

	// last pixel of the line
	assign line_end = (hc == H_LAST);

	// --------------------
	// counters
	// --------------------

	always_ff @(posedge dclk or posedge clr)
	begin
		if (clr)
		begin
			hc <= '0;
			vc <= '0;
		end
		else if (line_end)
		begin
			hc <= '0;
			// frame wrap after line 520
			if (vc == V_LAST)
				vc <= '0;
			else
				vc <= vc + 1'b1;
		end
		else
		begin
			hc <= hc + 1'b1;
		end
	end

	// --------------------
	// decode
	// --------------------

	assign rst.hc = hc;
	assign rst.vc = vc;

	// wraps outside the active area, flags qualify it
	assign rst.ax = hc - vga_pkg::coord_t'(`VGA_HBP);
	assign rst.ay = vc - vga_pkg::coord_t'(`VGA_VBP);

	assign rst.active_h = (hc >= vga_pkg::coord_t'(`VGA_HBP)) &&
		(hc < vga_pkg::coord_t'(`VGA_HFP));
	assign rst.active_v = (vc >= vga_pkg::coord_t'(`VGA_VBP)) &&
		(vc < vga_pkg::coord_t'(`VGA_VFP));

	// pulses at the start of line and frame
	assign rst.hsync_n = (hc >= vga_pkg::coord_t'(`VGA_HPULSE));
	assign rst.vsync_n = (vc >= vga_pkg::coord_t'(`VGA_VPULSE));

	// line counter never runs past 799
	a_hc_range: assert property (@(posedge dclk) disable iff (clr)
		hc < vga_pkg::coord_t'(`VGA_HPIXELS));

	// line number moves only across a line wrap
	a_vc_step: assert property (@(posedge dclk) disable iff (clr)
		$changed(vc) |-> $past(line_end));

endmodule

//--- title_banner.sv
`include "vga_macros.svh"

module title_banner
(
	raster_if.sink rst,
	output logic hit,
	output vga_pkg::rgb_t color
);

	localparam int NBOX = 28;
	// boxes of the two D letters
	localparam logic [NBOX-1:0] BOX_RED = 28'h0060006;

	vga_pkg::coord_t dx;
	vga_pkg::coord_t dy;
	logic [NBOX-1:0] box;

	// inclusive rectangle test
	function automatic logic in_rect(input vga_pkg::coord_t x, input vga_pkg::coord_t y,
		input vga_pkg::coord_t x0, input vga_pkg::coord_t x1,
		input vga_pkg::coord_t y0, input vga_pkg::coord_t y1);
		return (x >= x0) && (x <= x1) && (y >= y0) && (y <= y1);
	endfunction

	// offset from the banner corner, huge when left of or above it
	assign dx = rst.ax - vga_pkg::coord_t'(`TITLE_X0);
	assign dy = rst.ay - vga_pkg::coord_t'(`TITLE_Y0);

	// --------------------
	// letter boxes, in drawing order
	// --------------------

	// underline
	assign box[0] = in_rect(rst.ax, rst.ay, `TITLE_UL_X0, `TITLE_UL_X1,
		`TITLE_UL_Y0, `TITLE_UL_Y1);
	// D, taller than the rest
	assign box[1] = in_rect(dx, dy, 0, 15, 0, 35);
	assign box[2] = in_rect(dx, dy, 15, 20, 5, 30);
	// E
	assign box[3] = in_rect(dx, dy, 25, 30, 0, 25);
	assign box[4] = in_rect(dx, dy, 30, 40, 0, 5);
	assign box[5] = in_rect(dx, dy, 30, 40, 10, 15);
	assign box[6] = in_rect(dx, dy, 30, 40, 20, 25);
	// F
	assign box[7] = in_rect(dx, dy, 45, 50, 0, 25);
	assign box[8] = in_rect(dx, dy, 45, 60, 0, 5);
	assign box[9] = in_rect(dx, dy, 45, 60, 10, 15);
	// E
	assign box[10] = in_rect(dx, dy, 65, 70, 0, 25);
	assign box[11] = in_rect(dx, dy, 70, 80, 0, 5);
	assign box[12] = in_rect(dx, dy, 70, 80, 10, 15);
	assign box[13] = in_rect(dx, dy, 70, 80, 20, 25);
	// N, two posts and a short top link
	assign box[14] = in_rect(dx, dy, 85, 90, 0, 25);
	assign box[15] = in_rect(dx, dy, 90, 95, 0, 5);
	assign box[16] = in_rect(dx, dy, 95, 100, 0, 25);
	// D
	assign box[17] = in_rect(dx, dy, 105, 115, 0, 25);
	assign box[18] = in_rect(dx, dy, 115, 120, 5, 20);
	// E
	assign box[19] = in_rect(dx, dy, 125, 130, 0, 25);
	assign box[20] = in_rect(dx, dy, 130, 140, 0, 5);
	assign box[21] = in_rect(dx, dy, 130, 140, 10, 15);
	assign box[22] = in_rect(dx, dy, 130, 140, 20, 25);
	// R, stem down past the baseline
	assign box[23] = in_rect(dx, dy, 145, 150, 0, 35);
	assign box[24] = in_rect(dx, dy, 150, 155, 0, 5);
	assign box[25] = in_rect(dx, dy, 150, 155, 15, 20);
	assign box[26] = in_rect(dx, dy, 155, 160, 5, 15);
	assign box[27] = in_rect(dx, dy, 155, 160, 20, 35);

	// later box paints over earlier ones
	always_comb
	begin
		hit = 1'b0;
		color = vga_pkg::C_BLACK;
		for (int i = 0; i < NBOX; i++)
		begin
			if (box[i])
			begin
				hit = 1'b1;
				color = BOX_RED[i] ? vga_pkg::C_RED : vga_pkg::C_WHITE;
			end
		end
	end

endmodule

//--- sprite_layer.sv
`include "vga_macros.svh"

module sprite_layer
(
	raster_if.sink rst,
	input vga_pkg::coord_t player_x,
	input vga_pkg::coord_t player_y,
	input vga_pkg::coord_t boss_x,
	input vga_pkg::coord_t boss_y,
	input vga_pkg::coord_t row1_x,
	input vga_pkg::coord_t row1_y,
	input vga_pkg::coord_t row2_x,
	input vga_pkg::coord_t row2_y,
	input vga_pkg::coord_t shot_x,
	input vga_pkg::coord_t shot_y,
	input vga_pkg::enemy_mask_t row1_hit,
	input vga_pkg::enemy_mask_t row2_hit,
	output logic hit,
	output vga_pkg::rgb_t color
);

	localparam vga_pkg::coord_t HALF = vga_pkg::coord_t'(`SPRITE_HALF);
	localparam vga_pkg::coord_t SHOT_W = vga_pkg::coord_t'(`SHOT_HALF_W);
	localparam vga_pkg::coord_t SHOT_H = vga_pkg::coord_t'(`SHOT_HALF_H);

	logic player_box;
	logic boss_box;
	logic shot_box;
	logic [`ENEMY_SLOTS-1:0] row1_box;
	logic [`ENEMY_SLOTS-1:0] row2_box;

	// box around a centre, edges wrap at zero
	function automatic logic in_box(input vga_pkg::coord_t px, input vga_pkg::coord_t py,
		input vga_pkg::coord_t cx, input vga_pkg::coord_t cy,
		input vga_pkg::coord_t hw, input vga_pkg::coord_t hh);
		return (px >= cx - hw) && (px <= cx + hw) && (py >= cy - hh) && (py <= cy + hh);
	endfunction

	// --------------------
	// box tests
	// --------------------

	// 21x21 squares
	assign player_box = in_box(rst.ax, rst.ay, player_x, player_y, HALF, HALF);
	assign boss_box = in_box(rst.ax, rst.ay, boss_x, boss_y, HALF, HALF);

	// shot only while it is at or above the player
	assign shot_box = (shot_y <= player_y) &&
		in_box(rst.ax, rst.ay, shot_x, shot_y, SHOT_W, SHOT_H);

	// enemy slots step right from the row origin
	genvar k;
	generate
		for (k = 0; k < `ENEMY_SLOTS; k++)
		begin : g_slot
			localparam vga_pkg::coord_t OFS = vga_pkg::coord_t'(k * `ENEMY_PITCH);

			// destroyed slots drop out
			assign row1_box[k] = !row1_hit[k] &&
				in_box(rst.ax, rst.ay, row1_x + OFS, row1_y, HALF, HALF);
			assign row2_box[k] = !row2_hit[k] &&
				in_box(rst.ax, rst.ay, row2_x + OFS, row2_y, HALF, HALF);
		end
	endgenerate

	// --------------------
	// priority
	// --------------------

	// player at the bottom, shot on top
	always_comb
	begin
		hit = player_box | boss_box | (|row1_box) | (|row2_box) | shot_box;
		color = vga_pkg::C_BLACK;
		if (player_box)
			color = vga_pkg::C_WHITE;
		if (boss_box)
			color = vga_pkg::C_MAGENTA;
		if (|row1_box)
			color = vga_pkg::C_RED;
		if (|row2_box)
			color = vga_pkg::C_GREEN;
		if (shot_box)
			color = vga_pkg::C_WHITE;
	end

endmodule

//--- pixel_mux.sv
`include "vga_macros.svh"

module pixel_mux
(
	input logic dclk,
	input logic clr,
	input logic play,
	input logic gameover,
	raster_if.sink rst,
	input logic title_hit,
	input logic sprite_hit,
	input vga_pkg::rgb_t title_color,
	input vga_pkg::rgb_t sprite_color,
	output logic [2:0] red,
	output logic [2:0] green,
	output logic [1:0] blue,
	output logic hsync,
	output logic vsync
);

	localparam vga_pkg::coord_t BAR_L = vga_pkg::coord_t'(`VGA_BAR_W);
	localparam vga_pkg::coord_t BAR_R = vga_pkg::coord_t'(`VGA_ACTIVE_W - `VGA_BAR_W);

	vga_pkg::rgb_t pix;
	vga_pkg::rgb_t pix_q;
	logic side_bar;

	// first and last 80 columns
	assign side_bar = (rst.ax < BAR_L) || (rst.ax >= BAR_R);

	// --------------------
	// colour select
	// --------------------

	always_comb
	begin
		pix = vga_pkg::C_BLACK;
		if (rst.active_v && rst.active_h)
		begin
			if (side_bar)
				pix = vga_pkg::C_WHITE;
			else if (!play)
				pix = title_hit ? title_color : vga_pkg::C_BLACK;
			else if (gameover)
				pix = vga_pkg::C_RED;
			else
				pix = sprite_hit ? sprite_color : vga_pkg::C_BLACK;
		end
	end

	// colour and sync leave on the same edge
	always_ff @(posedge dclk or posedge clr)
	begin
		if (clr)
		begin
			pix_q <= vga_pkg::C_BLACK;
			hsync <= 1'b0;
			vsync <= 1'b0;
		end
		else
		begin
			pix_q <= pix;
			hsync <= rst.hsync_n;
			vsync <= rst.vsync_n;
		end
	end

	assign red = pix_q.r;
	assign green = pix_q.g;
	assign blue = pix_q.b;

	// vertical pulse sits in the blanking lines
	a_vsync_black: assert property (@(posedge dclk) disable iff (clr)
		!vsync |-> (pix_q == vga_pkg::C_BLACK));

endmodule

//--- defender_display.sv
module defender_display
(
	input logic dclk,
	input logic clr,
	input logic play,
	input logic gameover,
	input vga_pkg::coord_t player_x,
	input vga_pkg::coord_t player_y,
	input vga_pkg::coord_t boss_x,
	input vga_pkg::coord_t boss_y,
	input vga_pkg::coord_t row1_x,
	input vga_pkg::coord_t row1_y,
	input vga_pkg::coord_t row2_x,
	input vga_pkg::coord_t row2_y,
	input vga_pkg::coord_t shot_x,
	input vga_pkg::coord_t shot_y,
	input vga_pkg::enemy_mask_t collide,
	input vga_pkg::enemy_mask_t collide2,
	output logic hsync,
	output logic vsync,
	output logic [2:0] red,
	output logic [2:0] green,
	output logic [1:0] blue
);

	// layer results into the output stage
	logic title_hit;
	logic sprite_hit;
	vga_pkg::rgb_t title_color;
	vga_pkg::rgb_t sprite_color;

	// raster position shared by all stages
	raster_if rst_bus ();

	vga_timing u_timing
	(
		.dclk (dclk),
		.clr (clr),
		.rst (rst_bus.source)
	);

	// title screen
	title_banner u_title
	(
		.rst (rst_bus.sink),
		.hit (title_hit),
		.color (title_color)
	);

	// play field objects
	sprite_layer u_sprites
	(
		.rst (rst_bus.sink),
		.player_x (player_x),
		.player_y (player_y),
		.boss_x (boss_x),
		.boss_y (boss_y),
		.row1_x (row1_x),
		.row1_y (row1_y),
		.row2_x (row2_x),
		.row2_y (row2_y),
		.shot_x (shot_x),
		.shot_y (shot_y),
		.row1_hit (collide),
		.row2_hit (collide2),
		.hit (sprite_hit),
		.color (sprite_color)
	);

	pixel_mux u_mux
	(
		.dclk (dclk),
		.clr (clr),
		.play (play),
		.gameover (gameover),
		.rst (rst_bus.sink),
		.title_hit (title_hit),
		.sprite_hit (sprite_hit),
		.title_color (title_color),
		.sprite_color (sprite_color),
		.red (red),
		.green (green),
		.blue (blue),
		.hsync (hsync),
		.vsync (vsync)
	);

endmodule

//--- tb_defender_display.sv
`include "vga_macros.svh"

module tb_defender_display;

	timeunit 1ns;
	timeprecision 1ps;

	// --------------------
	// scene layout, active-area pixels
	// --------------------

	localparam int PLAYER_X = 200;
	localparam int PLAYER_Y = 420;
	localparam int BOSS_X = 450;
	localparam int BOSS_Y = 100;
	localparam int ROW1_Y = 180;
	localparam int ROW2_Y = 250;
	localparam int SHOT_X = 200;
	// above the player, then below it
	localparam int SHOT_Y_UP = 300;
	localparam int SHOT_Y_LOW = 440;
	// title, gameover, four play frames, low shot frame
	localparam int NSCEN = 7;
	// two whole frames
	localparam int WAIT_LIMIT = 2 * `VGA_HPIXELS * `VGA_VLINES;

	logic dclk = 1'b0;
	logic clr;
	logic play;
	logic gameover;
	vga_pkg::coord_t player_x;
	vga_pkg::coord_t player_y;
	vga_pkg::coord_t boss_x;
	vga_pkg::coord_t boss_y;
	vga_pkg::coord_t row1_x;
	vga_pkg::coord_t row1_y;
	vga_pkg::coord_t row2_x;
	vga_pkg::coord_t row2_y;
	vga_pkg::coord_t shot_x;
	vga_pkg::coord_t shot_y;
	vga_pkg::enemy_mask_t collide;
	vga_pkg::enemy_mask_t collide2;
	logic hsync;
	logic vsync;
	logic [2:0] red;
	logic [2:0] green;
	logic [1:0] blue;

	// own raster counters, pos is the pixel now on the outputs
	int cnt_h;
	int cnt_v;
	int pos_h;
	int pos_v;
	int ax;
	int ay;
	logic active;
	logic in_mid;
	logic ul_pt;
	logic d_pt;
	logic gap_pt;
	logic spr_chk;
	vga_pkg::rgb_t spr_exp;
	logic [7:0] pix;

	int errors = 0;
	int timeouts = 0;
	int checks = 0;

	defender_display u_dut
	(
		.dclk (dclk),
		.clr (clr),
		.play (play),
		.gameover (gameover),
		.player_x (player_x),
		.player_y (player_y),
		.boss_x (boss_x),
		.boss_y (boss_y),
		.row1_x (row1_x),
		.row1_y (row1_y),
		.row2_x (row2_x),
		.row2_y (row2_y),
		.shot_x (shot_x),
		.shot_y (shot_y),
		.collide (collide),
		.collide2 (collide2),
		.hsync (hsync),
		.vsync (vsync),
		.red (red),
		.green (green),
		.blue (blue)
	);

	// 100 ns period
	always #50 dclk = ~dclk;

	// --------------------
	// position tracking
	// --------------------

	always_ff @(posedge dclk or posedge clr)
	begin
		if (clr)
		begin
			cnt_h <= 0;
			cnt_v <= 0;
			pos_h <= 0;
			pos_v <= 0;
		end
		else
		begin
			// outputs lag the counters by one pixel
			pos_h <= cnt_h;
			pos_v <= cnt_v;
			if (cnt_h == `VGA_HPIXELS - 1)
			begin
				cnt_h <= 0;
				cnt_v <= (cnt_v == `VGA_VLINES - 1) ? 0 : cnt_v + 1;
			end
			else
				cnt_h <= cnt_h + 1;
		end
	end

	assign ax = pos_h - `VGA_HBP;
	assign ay = pos_v - `VGA_VBP;
	assign active = (pos_h >= `VGA_HBP) && (pos_h < `VGA_HFP) &&
		(pos_v >= `VGA_VBP) && (pos_v < `VGA_VFP);
	assign in_mid = active && (ax >= `VGA_BAR_W) && (ax < `VGA_ACTIVE_W - `VGA_BAR_W);
	assign pix = {red, green, blue};

	// title probes: underline, inside first D, empty sky
	assign ul_pt = (ax == 300) && (ay == 232);
	assign d_pt = (ax == 225) && (ay == 220);
	assign gap_pt = (ax == 400) && (ay == 100);

	// expected colour at each sprite centre
	always_comb
	begin
		spr_chk = 1'b0;
		spr_exp = vga_pkg::C_BLACK;
		if ((ax == int'(player_x)) && (ay == int'(player_y)))
		begin
			spr_chk = 1'b1;
			spr_exp = vga_pkg::C_WHITE;
		end
		if ((ax == int'(boss_x)) && (ay == int'(boss_y)))
		begin
			spr_chk = 1'b1;
			spr_exp = vga_pkg::C_MAGENTA;
		end
		for (int k = 0; k < `ENEMY_SLOTS; k++)
		begin
			// hit slots leave black field behind
			if ((ax == int'(row1_x) + k * `ENEMY_PITCH) && (ay == int'(row1_y)))
			begin
				spr_chk = 1'b1;
				spr_exp = collide[k] ? vga_pkg::C_BLACK : vga_pkg::C_RED;
			end
			if ((ax == int'(row2_x) + k * `ENEMY_PITCH) && (ay == int'(row2_y)))
			begin
				spr_chk = 1'b1;
				spr_exp = collide2[k] ? vga_pkg::C_BLACK : vga_pkg::C_GREEN;
			end
		end
		// shot hidden once below the player
		if ((ax == int'(shot_x)) && (ay == int'(shot_y)))
		begin
			spr_chk = 1'b1;
			spr_exp = (shot_y <= player_y) ? vga_pkg::C_WHITE : vga_pkg::C_BLACK;
		end
	end

	// --------------------
	// checks
	// --------------------

	task automatic log_mismatch(input string name, input logic [7:0] got,
		input logic [7:0] exp);
		errors++;
		$display("Error: %0d ns %s got %h expected %h", $time, name, got, exp);
	endtask

	a_hsync: assert property (@(posedge dclk) disable iff (clr)
		hsync == (pos_h >= `VGA_HPULSE))
		else log_mismatch("hsync", $sampled(hsync), $sampled(pos_h) >= `VGA_HPULSE);

	a_vsync: assert property (@(posedge dclk) disable iff (clr)
		vsync == (pos_v >= `VGA_VPULSE))
		else log_mismatch("vsync", $sampled(vsync), $sampled(pos_v) >= `VGA_VPULSE);

	// blanking in every mode
	a_blank: assert property (@(posedge dclk) disable iff (clr)
		!active |-> (pix == vga_pkg::C_BLACK))
		else log_mismatch("rgb blank", $sampled(pix), vga_pkg::C_BLACK);

	a_bars: assert property (@(posedge dclk) disable iff (clr)
		(active && !in_mid) |-> (pix == vga_pkg::C_WHITE))
		else log_mismatch("rgb bar", $sampled(pix), vga_pkg::C_WHITE);

	a_title_ul: assert property (@(posedge dclk) disable iff (clr)
		(!play && ul_pt) |-> (pix == vga_pkg::C_WHITE))
		else log_mismatch("rgb underline", $sampled(pix), vga_pkg::C_WHITE);

	a_title_d: assert property (@(posedge dclk) disable iff (clr)
		(!play && d_pt) |-> (pix == vga_pkg::C_RED))
		else log_mismatch("rgb letter d", $sampled(pix), vga_pkg::C_RED);

	a_title_gap: assert property (@(posedge dclk) disable iff (clr)
		(!play && gap_pt) |-> (pix == vga_pkg::C_BLACK))
		else log_mismatch("rgb title gap", $sampled(pix), vga_pkg::C_BLACK);

	a_over: assert property (@(posedge dclk) disable iff (clr)
		(play && gameover && in_mid) |-> (pix == vga_pkg::C_RED))
		else log_mismatch("rgb gameover", $sampled(pix), vga_pkg::C_RED);

	a_sprite: assert property (@(posedge dclk) disable iff (clr)
		(play && !gameover && spr_chk) |-> (pix == spr_exp))
		else log_mismatch("rgb sprite", $sampled(pix), $sampled(spr_exp));

	// probe points actually visited
	always @(posedge dclk)
	begin
		if (!clr && ((!play && (ul_pt || d_pt || gap_pt)) || (play && !gameover && spr_chk)))
			checks++;
	end

	// --------------------
	// stimulus
	// --------------------

	// first pixel of a frame, on a falling edge
	task automatic wait_frame_start();
		int n = 0;
		do
		begin
			@(negedge dclk);
			n++;
		end
		while (!((pos_h == 0) && (pos_v == 0)) && (n < WAIT_LIMIT));
		if (!((pos_h == 0) && (pos_v == 0)))
		begin
			timeouts++;
			$display("timeout: no frame start seen within %0d cycles", WAIT_LIMIT);
		end
	endtask

	// called inside the vsync lines only
	task automatic load_scenario(input int s);
		play = (s != 0);
		gameover = (s == 1);
		// last slot stays clear of the right bar
		row1_x = vga_pkg::coord_t'(100 + $urandom % 281);
		row2_x = vga_pkg::coord_t'(100 + $urandom % 281);
		collide = vga_pkg::enemy_mask_t'($urandom);
		collide2 = vga_pkg::enemy_mask_t'($urandom);
		shot_y = vga_pkg::coord_t'((s == NSCEN - 1) ? SHOT_Y_LOW : SHOT_Y_UP);
	endtask

	initial
	begin
		int s;
		void'($urandom(32'h8ad3_4ebb));
		clr = 1'b1;
		play = 1'b0;
		gameover = 1'b0;
		player_x = vga_pkg::coord_t'(PLAYER_X);
		player_y = vga_pkg::coord_t'(PLAYER_Y);
		boss_x = vga_pkg::coord_t'(BOSS_X);
		boss_y = vga_pkg::coord_t'(BOSS_Y);
		row1_x = vga_pkg::coord_t'(150);
		row1_y = vga_pkg::coord_t'(ROW1_Y);
		row2_x = vga_pkg::coord_t'(170);
		row2_y = vga_pkg::coord_t'(ROW2_Y);
		shot_x = vga_pkg::coord_t'(SHOT_X);
		shot_y = vga_pkg::coord_t'(SHOT_Y_UP);
		collide = '0;
		collide2 = '0;
		repeat (5) @(negedge dclk);
		clr = 1'b0;
		wait_frame_start();
		// one whole frame per scenario
		for (s = 0; (s < NSCEN) && (timeouts == 0); s++)
		begin
			load_scenario(s);
			wait_frame_start();
		end
		if (checks == 0)
			$display("no title or sprite probe point was reached");
		$display("checks=%0d errors=%0d timeouts=%0d", checks, errors, timeouts);
		if ((errors == 0) && (timeouts == 0) && (checks > 0))
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

//--- build.f
+incdir+.
vga_pkg.sv
raster_if.sv
vga_timing.sv
title_banner.sv
sprite_layer.sv
pixel_mux.sv
defender_display.sv
tb_defender_display.sv

//--- Makefile
# Verilator build and run for the defender display testbench

VERILATOR ?= verilator
TOP ?= tb_defender_display
FILELIST ?= build.f
OBJDIR ?= obj_dir
LOG ?= sim.log
TIMESCALE ?= 1ns/1ps
VFLAGS ?= --binary --assert --timing -Wno-fatal --timescale $(TIMESCALE)
LINTFLAGS ?= --lint-only -Wall --timing --timescale $(TIMESCALE)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJDIR) -o V$(TOP)

# pass only when the log holds the pass line
run: build
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "^RESULT: PASS$$" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJDIR) $(LOG)
